// File: verilog/mt_defs.svh
`ifndef MT_DEFS_SVH
`define MT_DEFS_SVH

// data path
`define MT_DATA_W      32
`define MT_MASK_W      4

// word address carried by a network packet
`define MT_NET_ADDR_W  14

// tile coordinates
`define MT_X_W         4
`define MT_Y_W         4

// scratchpad geometry, 2 banks of 256 words give a 9 bit word index
`define MT_BANK_WORDS  256
`define MT_NUM_BANKS   2
`define MT_LOCAL_W     9

// network endpoint sizing
`define MT_FIFO_ELS    4
`define MT_MAX_CREDITS 8

`endif

// File: verilog/mt_pkg.sv
`default_nettype none

`include "mt_defs.svh"

package mt_pkg;

   // opcodes understood by the endpoint
   typedef enum logic [1:0]
   {
      OP_STORE    = 2'd0,
      OP_FREEZE   = 2'd1,
      OP_UNFREEZE = 2'd2
   } mt_op_e;

   // one network packet
   // addr is a word address, the byte offset is already stripped
   typedef struct packed
   {
      mt_op_e                    op;
      logic [`MT_NET_ADDR_W-1:0] addr;
      logic [`MT_DATA_W-1:0]     data;
      logic [`MT_MASK_W-1:0]     mask;
      logic [`MT_X_W-1:0]        dest_x;
      logic [`MT_Y_W-1:0]        dest_y;
      logic [`MT_X_W-1:0]        src_x;
      logic [`MT_Y_W-1:0]        src_y;
   } mt_packet_s;

   // flat width for the top level packet ports
   localparam int MT_PACKET_W = $bits(mt_packet_s);

endpackage

`default_nettype wire

// File: verilog/mem_port_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "mt_defs.svh"

// one request port into the banked scratchpad
interface mem_port_if;

   // request side, held while v is high
   logic                   v;
   logic                   w;
   logic [`MT_LOCAL_W-1:0] addr;
   logic [`MT_DATA_W-1:0]  wdata;
   logic [`MT_MASK_W-1:0]  mask;

   // accept strobe and read return, rv one cycle after yumi
   logic                   yumi;
   logic                   rv;
   logic [`MT_DATA_W-1:0]  rdata;

   modport requester (output v, w, addr, wdata, mask,
                      input  yumi, rv, rdata);

   modport server    (input  v, w, addr, wdata, mask,
                      output yumi, rv, rdata);

endinterface

`default_nettype wire

// File: verilog/net_endpoint.sv
`timescale 1ns/1ps
`default_nettype none

`include "mt_defs.svh"

module net_endpoint
   (
   input  wire                              clk_i,
   input  wire                              arst_n_i,
   input  wire [`MT_X_W-1:0]                my_x_i,
   input  wire [`MT_Y_W-1:0]                my_y_i,
   input  wire                              net_in_v_i,
   input  wire [mt_pkg::MT_PACKET_W-1:0]    net_in_pkt_i,
   output logic                             net_in_ready_o,
   output logic                             net_out_v_o,
   output logic [mt_pkg::MT_PACKET_W-1:0]   net_out_pkt_o,
   input  wire                              net_out_ready_i,
   input  wire                              credit_return_i,
   input  wire                              out_v_i,
   input  wire mt_pkg::mt_packet_s          out_pkt_i,
   output logic                             out_ready_o,
   mem_port_if.requester                    net_port,
   output logic                             freeze_o,
   output logic                             outstanding_o
   );

   import mt_pkg::*;

   localparam int PTR_W  = $clog2(`MT_FIFO_ELS);
   localparam int CNT_W  = $clog2(`MT_FIFO_ELS + 1);
   localparam int CRED_W = $clog2(`MT_MAX_CREDITS + 1);

   mt_packet_s          fifo_mem [`MT_FIFO_ELS];
   logic [PTR_W-1:0]    wr_ptr_r;
   logic [PTR_W-1:0]    rd_ptr_r;
   logic [CNT_W-1:0]    count_r;
   mt_packet_s          head;
   logic                head_v;
   logic                head_ctrl;
   logic                push;
   logic                pop;
   logic                freeze_r;
   logic [CRED_W-1:0]   credits_r;
   logic                send;
   mt_packet_s          stamped;

   // receive fifo
   assign net_in_ready_o = (count_r != CNT_W'(`MT_FIFO_ELS));
   assign push           = net_in_v_i & net_in_ready_o;
   assign head           = fifo_mem[rd_ptr_r];
   assign head_v         = (count_r != '0);
   assign head_ctrl      = head_v & (head.op != OP_STORE);

   // control packets leave the head in one cycle, stores wait for the bank
   assign pop = head_ctrl | (net_port.v & net_port.yumi);

   always_ff @(posedge clk_i)
   begin
      if (push)
      begin
         fifo_mem[wr_ptr_r] <= mt_packet_s'(net_in_pkt_i);
      end
   end

   // depth is a power of two so the pointers wrap by themselves
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         wr_ptr_r <= '0;
         rd_ptr_r <= '0;
         count_r  <= '0;
         freeze_r <= 1'b1;
      end
      else
      begin
         if (push)
         begin
            wr_ptr_r <= wr_ptr_r + 1'b1;
         end
         if (pop)
         begin
            rd_ptr_r <= rd_ptr_r + 1'b1;
         end
         if (push & ~pop)
         begin
            count_r <= count_r + 1'b1;
         end
         else if (pop & ~push)
         begin
            count_r <= count_r - 1'b1;
         end
         if (head_ctrl)
         begin
            freeze_r <= (head.op == OP_FREEZE);
         end
      end
   end

   assign freeze_o = freeze_r;

   // head store goes straight to the network bank port
   assign net_port.v     = head_v & (head.op == OP_STORE);
   assign net_port.w     = 1'b1;
   assign net_port.addr  = head.addr[`MT_LOCAL_W-1:0];
   assign net_port.wdata = head.data;
   assign net_port.mask  = head.mask;

   // outgoing path, gated by the credit count
   assign out_ready_o = net_out_ready_i & (credits_r != '0);
   assign net_out_v_o = out_v_i & (credits_r != '0);
   assign send        = out_v_i & out_ready_o;

   always_comb
   begin
      stamped       = out_pkt_i;
      stamped.src_x = my_x_i;
      stamped.src_y = my_y_i;
   end

   assign net_out_pkt_o = stamped;

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         credits_r <= CRED_W'(`MT_MAX_CREDITS);
      end
      else if (send & ~credit_return_i)
      begin
         credits_r <= credits_r - 1'b1;
      end
      else if (credit_return_i & ~send)
      begin
         credits_r <= credits_r + 1'b1;
      end
   end

   assign outstanding_o = (credits_r < CRED_W'(`MT_MAX_CREDITS));

endmodule

`default_nettype wire

// File: verilog/dport_router.sv
`timescale 1ns/1ps
`default_nettype none

`include "mt_defs.svh"

module dport_router
   (
   input  wire                        clk_i,
   input  wire                        arst_n_i,
   input  wire                        dmem_v_i,
   input  wire                        dmem_w_i,
   input  wire [31:0]                 dmem_addr_i,
   input  wire [`MT_DATA_W-1:0]       dmem_wdata_i,
   input  wire [`MT_MASK_W-1:0]       dmem_mask_i,
   input  wire                        dmem_reserve_i,
   output logic                       dmem_yumi_o,
   output logic                       dmem_rv_o,
   output logic [`MT_DATA_W-1:0]      dmem_rdata_o,
   output logic                       reservation_o,
   output logic                       out_v_o,
   output mt_pkg::mt_packet_s         out_pkt_o,
   input  wire                        out_ready_i,
   mem_port_if.requester              dmem_port,
   input  wire                        net_store_v_i,
   input  wire                        net_store_yumi_i,
   input  wire [`MT_LOCAL_W-1:0]      net_store_addr_i
   );

   import mt_pkg::*;

   logic                   is_remote;
   logic [`MT_LOCAL_W-1:0] local_idx;
   logic                   reserve_set;
   logic                   reserve_clr;
   logic                   res_r;
   logic [`MT_LOCAL_W-1:0] res_idx_r;

   // bit 31 of the byte address marks a remote access
   assign is_remote = dmem_addr_i[31];
   assign local_idx = dmem_addr_i[2 +: `MT_LOCAL_W];

   // remote loads are not served, only remote stores leave the tile
   assign out_v_o          = dmem_v_i & is_remote & dmem_w_i;
   assign out_pkt_o.op     = OP_STORE;
   assign out_pkt_o.addr   = dmem_addr_i[2 +: `MT_NET_ADDR_W];
   assign out_pkt_o.data   = dmem_wdata_i;
   assign out_pkt_o.mask   = dmem_mask_i;
   assign out_pkt_o.dest_y = dmem_addr_i[29:26];
   assign out_pkt_o.dest_x = dmem_addr_i[25:22];
   // filled in by the endpoint
   assign out_pkt_o.src_x  = '0;
   assign out_pkt_o.src_y  = '0;

   // local side
   assign dmem_port.v     = dmem_v_i & ~is_remote;
   assign dmem_port.w     = dmem_w_i;
   assign dmem_port.addr  = local_idx;
   assign dmem_port.wdata = dmem_wdata_i;
   assign dmem_port.mask  = dmem_mask_i;

   assign dmem_yumi_o  = is_remote ? (out_v_o & out_ready_i) : dmem_port.yumi;
   assign dmem_rv_o    = dmem_port.rv;
   assign dmem_rdata_o = dmem_port.rdata;

   // load reserved, cleared by a network store to the same word
   assign reserve_set = dmem_port.v & dmem_port.yumi & ~dmem_w_i & dmem_reserve_i;
   assign reserve_clr = net_store_v_i & net_store_yumi_i & (net_store_addr_i == res_idx_r);

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         res_r <= 1'b0;
      end
      else if (reserve_set)
      begin
         res_r <= 1'b1;
      end
      else if (reserve_clr)
      begin
         res_r <= 1'b0;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (reserve_set)
      begin
         res_idx_r <= local_idx;
      end
   end

   assign reservation_o = res_r;

endmodule

`default_nettype wire

// File: verilog/banked_xbar.sv
`timescale 1ns/1ps
`default_nettype none

`include "mt_defs.svh"

module banked_xbar
   (
   input  wire                     clk_i,
   input  wire                     arst_n_i,
   input  wire                     imem_v_i,
   input  wire [`MT_LOCAL_W-1:0]   imem_addr_i,
   output logic                    imem_yumi_o,
   output logic                    imem_rv_o,
   output logic [`MT_DATA_W-1:0]   imem_rdata_o,
   mem_port_if.server              net_port,
   mem_port_if.server              dmem_port
   );

   localparam int NP        = 3;
   localparam int BANK_BITS = $clog2(`MT_NUM_BANKS);
   localparam int ROW_W     = `MT_LOCAL_W - BANK_BITS;

   // port 0 imem, port 1 network, port 2 dmem
   logic [NP-1:0]           port_v;
   logic [NP-1:0]           port_w;
   logic [`MT_DATA_W-1:0]   port_wdata [NP];
   logic [`MT_MASK_W-1:0]   port_mask [NP];
   logic [BANK_BITS-1:0]    port_bank [NP];
   logic [ROW_W-1:0]        port_row [NP];
   logic [NP-1:0]           bank_gnt [`MT_NUM_BANKS];
   logic [`MT_DATA_W-1:0]   bank_rdata [`MT_NUM_BANKS];
   logic [NP-1:0]           port_yumi;
   logic [NP-1:0]           rv_r;
   logic [BANK_BITS-1:0]    rd_bank_r [NP];

   assign port_v = {dmem_port.v, net_port.v, imem_v_i};
   assign port_w = {dmem_port.w, net_port.w, 1'b0};

   assign port_wdata[0] = '0;
   assign port_wdata[1] = net_port.wdata;
   assign port_wdata[2] = dmem_port.wdata;
   assign port_mask[0]  = '0;
   assign port_mask[1]  = net_port.mask;
   assign port_mask[2]  = dmem_port.mask;

   // swizzle, low word index bit picks the bank so neighbours interleave
   assign {port_row[0], port_bank[0]} = imem_addr_i;
   assign {port_row[1], port_bank[1]} = net_port.addr;
   assign {port_row[2], port_bank[2]} = dmem_port.addr;

   for (genvar b = 0; b < `MT_NUM_BANKS; b++)
   begin : g_bank
      logic [`MT_DATA_W-1:0] mem [`MT_BANK_WORDS];
      logic [`MT_DATA_W-1:0] rdata_r;
      logic [NP-1:0]         req;
      logic [NP-1:0]         gnt;
      logic [1:0]            sel;

      // fixed priority: dmem, then imem, network last
      always_comb
      begin
         for (int p = 0; p < NP; p++)
         begin
            req[p] = port_v[p] & (port_bank[p] == BANK_BITS'(b));
         end
         gnt = '0;
         sel = 2'd0;
         if (req[2])
         begin
            gnt[2] = 1'b1;
            sel    = 2'd2;
         end
         else if (req[0])
         begin
            gnt[0] = 1'b1;
            sel    = 2'd0;
         end
         else if (req[1])
         begin
            gnt[1] = 1'b1;
            sel    = 2'd1;
         end
      end

      always_ff @(posedge clk_i)
      begin
         if (|gnt)
         begin
            if (port_w[sel])
            begin
               for (int i = 0; i < `MT_MASK_W; i++)
               begin
                  if (port_mask[sel][i])
                  begin
                     mem[port_row[sel]][8*i +: 8] <= port_wdata[sel][8*i +: 8];
                  end
               end
            end
            else
            begin
               rdata_r <= mem[port_row[sel]];
            end
         end
      end

      assign bank_gnt[b]   = gnt;
      assign bank_rdata[b] = rdata_r;
   end

   // a port asks for one bank at a time
   always_comb
   begin
      port_yumi = '0;
      for (int b = 0; b < `MT_NUM_BANKS; b++)
      begin
         port_yumi = port_yumi | bank_gnt[b];
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         rv_r <= '0;
      end
      else
      begin
         rv_r <= port_yumi & ~port_w;
      end
   end

   // remember which bank holds each port's read data
   always_ff @(posedge clk_i)
   begin
      for (int p = 0; p < NP; p++)
      begin
         rd_bank_r[p] <= port_bank[p];
      end
   end

   assign imem_yumi_o     = port_yumi[0];
   assign imem_rv_o       = rv_r[0];
   assign imem_rdata_o    = bank_rdata[rd_bank_r[0]];
   assign net_port.yumi   = port_yumi[1];
   assign net_port.rv     = rv_r[1];
   assign net_port.rdata  = bank_rdata[rd_bank_r[1]];
   assign dmem_port.yumi  = port_yumi[2];
   assign dmem_port.rv    = rv_r[2];
   assign dmem_port.rdata = bank_rdata[rd_bank_r[2]];

endmodule

`default_nettype wire

// File: verilog/mem_tile.sv
`timescale 1ns/1ps
`default_nettype none

`include "mt_defs.svh"

module mem_tile
   (
   input  wire                              clk_i,
   input  wire                              arst_n_i,
   input  wire [`MT_X_W-1:0]                my_x_i,
   input  wire [`MT_Y_W-1:0]                my_y_i,
   // instruction port, read only
   input  wire                              imem_v_i,
   input  wire [31:0]                       imem_addr_i,
   output logic                             imem_yumi_o,
   output logic                             imem_rv_o,
   output logic [`MT_DATA_W-1:0]            imem_rdata_o,
   // data port
   input  wire                              dmem_v_i,
   input  wire                              dmem_w_i,
   input  wire [31:0]                       dmem_addr_i,
   input  wire [`MT_DATA_W-1:0]             dmem_wdata_i,
   input  wire [`MT_MASK_W-1:0]             dmem_mask_i,
   input  wire                              dmem_reserve_i,
   output logic                             dmem_yumi_o,
   output logic                             dmem_rv_o,
   output logic [`MT_DATA_W-1:0]            dmem_rdata_o,
   // network
   input  wire                              net_in_v_i,
   input  wire [mt_pkg::MT_PACKET_W-1:0]    net_in_pkt_i,
   output logic                             net_in_ready_o,
   output logic                             net_out_v_o,
   output logic [mt_pkg::MT_PACKET_W-1:0]   net_out_pkt_o,
   input  wire                              net_out_ready_i,
   input  wire                              credit_return_i,
   // status
   output logic                             freeze_o,
   output logic                             reservation_o,
   output logic                             outstanding_o
   );

   import mt_pkg::*;

   mem_port_if dmem_port ();
   mem_port_if net_port ();

   // remote stores from the router to the endpoint
   logic       out_v;
   logic       out_ready;
   mt_packet_s out_pkt;

   net_endpoint net_endpoint_i
      (
      .clk_i           (clk_i),
      .arst_n_i        (arst_n_i),
      .my_x_i          (my_x_i),
      .my_y_i          (my_y_i),
      .net_in_v_i      (net_in_v_i),
      .net_in_pkt_i    (net_in_pkt_i),
      .net_in_ready_o  (net_in_ready_o),
      .net_out_v_o     (net_out_v_o),
      .net_out_pkt_o   (net_out_pkt_o),
      .net_out_ready_i (net_out_ready_i),
      .credit_return_i (credit_return_i),
      .out_v_i         (out_v),
      .out_pkt_i       (out_pkt),
      .out_ready_o     (out_ready),
      .net_port        (net_port.requester),
      .freeze_o        (freeze_o),
      .outstanding_o   (outstanding_o)
      );

   dport_router dport_router_i
      (
      .clk_i            (clk_i),
      .arst_n_i         (arst_n_i),
      .dmem_v_i         (dmem_v_i),
      .dmem_w_i         (dmem_w_i),
      .dmem_addr_i      (dmem_addr_i),
      .dmem_wdata_i     (dmem_wdata_i),
      .dmem_mask_i      (dmem_mask_i),
      .dmem_reserve_i   (dmem_reserve_i),
      .dmem_yumi_o      (dmem_yumi_o),
      .dmem_rv_o        (dmem_rv_o),
      .dmem_rdata_o     (dmem_rdata_o),
      .reservation_o    (reservation_o),
      .out_v_o          (out_v),
      .out_pkt_o        (out_pkt),
      .out_ready_i      (out_ready),
      .dmem_port        (dmem_port.requester),
      // watch network stores for the reservation
      .net_store_v_i    (net_port.v),
      .net_store_yumi_i (net_port.yumi),
      .net_store_addr_i (net_port.addr)
      );

   banked_xbar banked_xbar_i
      (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .imem_v_i     (imem_v_i),
      .imem_addr_i  (imem_addr_i[2 +: `MT_LOCAL_W]),
      .imem_yumi_o  (imem_yumi_o),
      .imem_rv_o    (imem_rv_o),
      .imem_rdata_o (imem_rdata_o),
      .net_port     (net_port.server),
      .dmem_port    (dmem_port.server)
      );

endmodule

`default_nettype wire

// File: tb/mem_tile_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mt_defs.svh"

module mem_tile_tb;

   import mt_pkg::*;

   localparam int TIMEOUT_CYCLES = 3000;
   localparam int WORDS          = `MT_BANK_WORDS * `MT_NUM_BANKS;

   logic                     clk;
   logic                     arst_n;
   logic [`MT_X_W-1:0]       my_x;
   logic [`MT_Y_W-1:0]       my_y;
   logic                     imem_v;
   logic [31:0]              imem_addr;
   logic                     imem_yumi;
   logic                     imem_rv;
   logic [31:0]              imem_rdata;
   logic                     dmem_v;
   logic                     dmem_w;
   logic [31:0]              dmem_addr;
   logic [31:0]              dmem_wdata;
   logic [3:0]               dmem_mask;
   logic                     dmem_reserve;
   logic                     dmem_yumi;
   logic                     dmem_rv;
   logic [31:0]              dmem_rdata;
   logic                     net_in_v;
   logic [MT_PACKET_W-1:0]   net_in_pkt;
   logic                     net_in_ready;
   logic                     net_out_v;
   logic [MT_PACKET_W-1:0]   net_out_pkt;
   logic                     net_out_ready;
   logic                     credit_return;
   logic                     freeze;
   logic                     reservation;
   logic                     outstanding;

   // reference copy of the scratchpad
   logic [31:0]              model [WORDS];
   logic [15:0]              lfsr_q;
   int                       cycle_cnt;

   mem_tile mem_tile_i
      (
      .clk_i           (clk),
      .arst_n_i        (arst_n),
      .my_x_i          (my_x),
      .my_y_i          (my_y),
      .imem_v_i        (imem_v),
      .imem_addr_i     (imem_addr),
      .imem_yumi_o     (imem_yumi),
      .imem_rv_o       (imem_rv),
      .imem_rdata_o    (imem_rdata),
      .dmem_v_i        (dmem_v),
      .dmem_w_i        (dmem_w),
      .dmem_addr_i     (dmem_addr),
      .dmem_wdata_i    (dmem_wdata),
      .dmem_mask_i     (dmem_mask),
      .dmem_reserve_i  (dmem_reserve),
      .dmem_yumi_o     (dmem_yumi),
      .dmem_rv_o       (dmem_rv),
      .dmem_rdata_o    (dmem_rdata),
      .net_in_v_i      (net_in_v),
      .net_in_pkt_i    (net_in_pkt),
      .net_in_ready_o  (net_in_ready),
      .net_out_v_o     (net_out_v),
      .net_out_pkt_o   (net_out_pkt),
      .net_out_ready_i (net_out_ready),
      .credit_return_i (credit_return),
      .freeze_o        (freeze),
      .reservation_o   (reservation),
      .outstanding_o   (outstanding)
      );

   always #4 clk = ~clk;

   always @(posedge clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES)
      begin
         $display("timeout after %0d cycles, the DUT stopped responding", cycle_cnt);
         $display("TEST FAILED");
         $fatal(1, "timeout");
      end
   end

   task automatic check_bit(input string name, input logic got, input logic exp);
      assert (got === exp)
      else
      begin
         $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
         $display("TEST FAILED");
         $fatal(1, "mismatch");
      end
   endtask

   task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp)
      else
      begin
         $display("** Error at %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
         $display("TEST FAILED");
         $fatal(1, "mismatch");
      end
   endtask

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      logic fb;
      fb = s[15] ^ s[13] ^ s[12] ^ s[10];
      return {s[14:0], fb};
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_q = lfsr_next(lfsr_q);
         r      = {r[30:0], lfsr_q[0]};
      end
      return r;
   endfunction

   function automatic logic [31:0] merge_bytes(input logic [31:0] old_w, input logic [31:0] new_w,
                                                input logic [3:0] mask);
      logic [31:0] r;
      r = old_w;
      for (int i = 0; i < 4; i++)
      begin
         if (mask[i])
         begin
            r[8*i +: 8] = new_w[8*i +: 8];
         end
      end
      return r;
   endfunction

   function automatic logic [31:0] local_addr(input logic [8:0] idx);
      return {21'd0, idx, 2'b00};
   endfunction

   // bit 31 remote, dest_y 29:26, dest_x 25:22, word 15:2
   function automatic logic [31:0] remote_addr(input logic [3:0] dy, input logic [3:0] dx,
                                               input logic [13:0] word);
      return {1'b1, 1'b0, dy, dx, 6'd0, word, 2'b00};
   endfunction

   task automatic local_write(input logic [8:0] idx, input logic [31:0] data,
                              input logic [3:0] mask);
      @(posedge clk);
      #1;
      dmem_v     = 1'b1;
      dmem_w     = 1'b1;
      dmem_addr  = local_addr(idx);
      dmem_wdata = data;
      dmem_mask  = mask;
      @(negedge clk);
      while (dmem_yumi !== 1'b1)
      begin
         @(negedge clk);
      end
      @(posedge clk);
      #1;
      dmem_v = 1'b0;
      dmem_w = 1'b0;
      model[idx] = merge_bytes(model[idx], data, mask);
   endtask

   // rv must be low in the accept cycle, high for exactly the next one
   task automatic read_and_check(input logic from_imem, input logic [8:0] idx,
                                 input logic reserve);
      string port;
      port = from_imem ? "imem" : "dmem";
      @(posedge clk);
      #1;
      if (from_imem)
      begin
         imem_v    = 1'b1;
         imem_addr = local_addr(idx);
      end
      else
      begin
         dmem_v       = 1'b1;
         dmem_w       = 1'b0;
         dmem_addr    = local_addr(idx);
         dmem_reserve = reserve;
      end
      @(negedge clk);
      while ((from_imem ? imem_yumi : dmem_yumi) !== 1'b1)
      begin
         @(negedge clk);
      end
      check_bit({port, "_rv_o"}, from_imem ? imem_rv : dmem_rv, 1'b0);
      @(posedge clk);
      #1;
      imem_v       = 1'b0;
      dmem_v       = 1'b0;
      dmem_reserve = 1'b0;
      @(negedge clk);
      check_bit({port, "_rv_o"}, from_imem ? imem_rv : dmem_rv, 1'b1);
      check_word({port, "_rdata_o"}, from_imem ? imem_rdata : dmem_rdata, model[idx]);
      @(negedge clk);
      check_bit({port, "_rv_o"}, from_imem ? imem_rv : dmem_rv, 1'b0);
   endtask

   task automatic start_remote_store(input logic [3:0] dy, input logic [3:0] dx,
                                     input logic [13:0] word, input logic [31:0] data,
                                     input logic [3:0] mask);
      @(posedge clk);
      #1;
      dmem_v     = 1'b1;
      dmem_w     = 1'b1;
      dmem_addr  = remote_addr(dy, dx, word);
      dmem_wdata = data;
      dmem_mask  = mask;
   endtask

   task automatic finish_remote_store(input logic [3:0] dy, input logic [3:0] dx,
                                      input logic [13:0] word, input logic [31:0] data,
                                      input logic [3:0] mask);
      mt_packet_s pkt;
      @(negedge clk);
      while (dmem_yumi !== 1'b1)
      begin
         @(negedge clk);
      end
      pkt = mt_packet_s'(net_out_pkt);
      check_bit("net_out_v_o", net_out_v, 1'b1);
      check_word("net_out_pkt_o.op", 32'(pkt.op), 32'(OP_STORE));
      check_word("net_out_pkt_o.dest_y", 32'(pkt.dest_y), 32'(dy));
      check_word("net_out_pkt_o.dest_x", 32'(pkt.dest_x), 32'(dx));
      check_word("net_out_pkt_o.addr", 32'(pkt.addr), 32'(word));
      check_word("net_out_pkt_o.data", pkt.data, data);
      check_word("net_out_pkt_o.mask", 32'(pkt.mask), 32'(mask));
      check_word("net_out_pkt_o.src_x", 32'(pkt.src_x), 32'(my_x));
      check_word("net_out_pkt_o.src_y", 32'(pkt.src_y), 32'(my_y));
      @(posedge clk);
      #1;
      dmem_v = 1'b0;
      dmem_w = 1'b0;
   endtask

   task automatic send_packet(input mt_packet_s pkt);
      @(posedge clk);
      #1;
      net_in_v   = 1'b1;
      net_in_pkt = pkt;
      @(negedge clk);
      while (net_in_ready !== 1'b1)
      begin
         @(negedge clk);
      end
      @(posedge clk);
      #1;
      net_in_v = 1'b0;
   endtask

   task automatic net_store(input logic [8:0] idx, input logic [31:0] data,
                            input logic [3:0] mask);
      mt_packet_s pkt;
      pkt        = '0;
      pkt.op     = OP_STORE;
      pkt.addr   = 14'(idx);
      pkt.data   = data;
      pkt.mask   = mask;
      pkt.dest_x = my_x;
      pkt.dest_y = my_y;
      send_packet(pkt);
      model[idx] = merge_bytes(model[idx], data, mask);
   endtask

   // with a free bank each queued store leaves the FIFO in one cycle
   task automatic drain_wait();
      repeat (`MT_FIFO_ELS + 2) @(posedge clk);
   endtask

   task automatic check_reset_state();
      check_bit("freeze_o", freeze, 1'b1);
      check_bit("outstanding_o", outstanding, 1'b0);
      check_bit("reservation_o", reservation, 1'b0);
      check_bit("net_in_ready_o", net_in_ready, 1'b1);
      check_bit("net_out_v_o", net_out_v, 1'b0);
      check_bit("imem_yumi_o", imem_yumi, 1'b0);
      check_bit("imem_rv_o", imem_rv, 1'b0);
      check_bit("dmem_yumi_o", dmem_yumi, 1'b0);
      check_bit("dmem_rv_o", dmem_rv, 1'b0);
   endtask

   task automatic test_local_memory();
      logic [8:0] idx;
      // words 0 to 15 get known contents first
      for (int i = 0; i < 16; i++)
      begin
         local_write(9'(i), rand_bits(32), 4'hf);
      end
      for (int i = 0; i < 8; i++)
      begin
         idx = 9'(rand_bits(4));
         local_write(idx, rand_bits(32), 4'(rand_bits(4)));
      end
      for (int i = 0; i < 16; i++)
      begin
         read_and_check(1'b0, 9'(i), 1'b0);
         read_and_check(1'b1, 9'(i), 1'b0);
      end
   endtask

   task automatic test_bank_priority();
      // words 2 and 6 share bank 0
      @(posedge clk);
      #1;
      imem_v    = 1'b1;
      imem_addr = local_addr(9'd2);
      dmem_v    = 1'b1;
      dmem_w    = 1'b0;
      dmem_addr = local_addr(9'd6);
      @(negedge clk);
      check_bit("dmem_yumi_o", dmem_yumi, 1'b1);
      check_bit("imem_yumi_o", imem_yumi, 1'b0);
      @(posedge clk);
      #1;
      dmem_v = 1'b0;
      @(negedge clk);
      check_bit("dmem_rv_o", dmem_rv, 1'b1);
      check_word("dmem_rdata_o", dmem_rdata, model[6]);
      check_bit("imem_yumi_o", imem_yumi, 1'b1);
      @(posedge clk);
      #1;
      imem_v = 1'b0;
      @(negedge clk);
      check_bit("imem_rv_o", imem_rv, 1'b1);
      check_word("imem_rdata_o", imem_rdata, model[2]);
      // words 3 and 6 sit in different banks
      @(posedge clk);
      #1;
      imem_v    = 1'b1;
      imem_addr = local_addr(9'd3);
      dmem_v    = 1'b1;
      @(negedge clk);
      check_bit("dmem_yumi_o", dmem_yumi, 1'b1);
      check_bit("imem_yumi_o", imem_yumi, 1'b1);
      @(posedge clk);
      #1;
      imem_v = 1'b0;
      dmem_v = 1'b0;
      @(negedge clk);
      check_word("dmem_rdata_o", dmem_rdata, model[6]);
      check_word("imem_rdata_o", imem_rdata, model[3]);
      check_bit("imem_rv_o", imem_rv, 1'b1);
      check_bit("dmem_rv_o", dmem_rv, 1'b1);
   endtask

   task automatic test_remote_stores();
      logic [3:0]  dy;
      logic [3:0]  dx;
      logic [13:0] word;
      logic [31:0] data;
      logic [3:0]  mask;
      for (int n = 0; n <= `MT_MAX_CREDITS; n++)
      begin
         dy   = 4'(rand_bits(4));
         dx   = 4'(rand_bits(4));
         word = 14'(rand_bits(14));
         data = rand_bits(32);
         mask = 4'(rand_bits(4));
         start_remote_store(dy, dx, word, data, mask);
         if (n == `MT_MAX_CREDITS)
         begin
            // no credit left, the store must wait
            repeat (3)
            begin
               @(negedge clk);
               check_bit("dmem_yumi_o", dmem_yumi, 1'b0);
               check_bit("net_out_v_o", net_out_v, 1'b0);
               check_bit("outstanding_o", outstanding, 1'b1);
            end
            @(posedge clk);
            #1;
            credit_return = 1'b1;
            @(posedge clk);
            #1;
            credit_return = 1'b0;
         end
         finish_remote_store(dy, dx, word, data, mask);
         check_bit("outstanding_o", outstanding, 1'b1);
      end
      // hand back every credit
      @(posedge clk);
      #1;
      credit_return = 1'b1;
      repeat (`MT_MAX_CREDITS) @(posedge clk);
      #1;
      credit_return = 1'b0;
      @(negedge clk);
      check_bit("outstanding_o", outstanding, 1'b0);
   endtask

   task automatic test_incoming_stores();
      for (int i = 0; i < 4; i++)
      begin
         net_store(9'(rand_bits(4)), rand_bits(32), 4'(rand_bits(4)));
      end
      drain_wait();
      for (int i = 0; i < 16; i++)
      begin
         read_and_check(1'b0, 9'(i), 1'b0);
      end
      // dmem keeps bank 0 busy so stores to even words pile up
      @(posedge clk);
      #1;
      dmem_v    = 1'b1;
      dmem_w    = 1'b0;
      dmem_addr = local_addr(9'd0);
      for (int i = 0; i < `MT_FIFO_ELS; i++)
      begin
         net_store(9'(2 * i), rand_bits(32), 4'(rand_bits(4)));
      end
      @(negedge clk);
      check_bit("net_in_ready_o", net_in_ready, 1'b0);
      @(posedge clk);
      #1;
      dmem_v = 1'b0;
      @(negedge clk);
      while (net_in_ready !== 1'b1)
      begin
         @(negedge clk);
      end
      drain_wait();
      for (int i = 0; i < 8; i++)
      begin
         read_and_check(1'b0, 9'(i), 1'b0);
      end
   endtask

   task automatic send_control(input mt_op_e op, input logic exp_freeze);
      mt_packet_s pkt;
      pkt    = '0;
      pkt.op = op;
      send_packet(pkt);
      // takes effect one cycle after reaching the head
      @(negedge clk);
      check_bit("freeze_o", freeze, ~exp_freeze);
      @(negedge clk);
      check_bit("freeze_o", freeze, exp_freeze);
   endtask

   task automatic test_freeze();
      check_bit("freeze_o", freeze, 1'b1);
      send_control(OP_UNFREEZE, 1'b0);
      send_control(OP_FREEZE, 1'b1);
   endtask

   task automatic test_reservation();
      check_bit("reservation_o", reservation, 1'b0);
      read_and_check(1'b0, 9'd5, 1'b1);
      check_bit("reservation_o", reservation, 1'b1);
      net_store(9'd7, rand_bits(32), 4'hf);
      drain_wait();
      check_bit("reservation_o", reservation, 1'b1);
      net_store(9'd5, rand_bits(32), 4'hf);
      drain_wait();
      check_bit("reservation_o", reservation, 1'b0);
      read_and_check(1'b0, 9'd5, 1'b0);
      read_and_check(1'b0, 9'd7, 1'b0);
   endtask

   initial
   begin
      lfsr_q        = 16'd39;
      cycle_cnt     = 0;
      clk           = 1'b0;
      arst_n        = 1'b0;
      my_x          = 4'd3;
      my_y          = 4'd5;
      imem_v        = 1'b0;
      imem_addr     = '0;
      dmem_v        = 1'b0;
      dmem_w        = 1'b0;
      dmem_addr     = '0;
      dmem_wdata    = '0;
      dmem_mask     = '0;
      dmem_reserve  = 1'b0;
      net_in_v      = 1'b0;
      net_in_pkt    = '0;
      net_out_ready = 1'b1;
      credit_return = 1'b0;
      repeat (2) @(posedge clk);
      #1;
      arst_n = 1'b1;
      @(negedge clk);
      check_reset_state();
      test_local_memory();
      test_bank_priority();
      test_remote_stores();
      test_incoming_stores();
      test_freeze();
      test_reservation();
      $display("TEST OK");
      $finish;
   end

endmodule

`default_nettype wire

// File: mem_tile.f
+incdir+verilog
verilog/mt_pkg.sv
verilog/mem_port_if.sv
verilog/net_endpoint.sv
verilog/dport_router.sv
verilog/banked_xbar.sv
verilog/mem_tile.sv
tb/mem_tile_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = mem_tile_tb
FLIST     = mem_tile.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
